// File: hdl/spi_cmd_pkg.sv
`default_nettype none

package spi_cmd_pkg;

  // command word layout
  localparam int CMD_WIDTH  = 12;
  localparam int ADDR_WIDTH = 3;
  localparam int DATA_WIDTH = 8;

  // write view sends the whole word in one frame
  typedef struct packed {
    logic                  opcode;
    logic [ADDR_WIDTH-1:0] addr;
    logic [DATA_WIDTH-1:0] data;
  } spi_wr_cmd_t;

  // read view carries the turnaround length in its low byte
  typedef struct packed {
    logic                  opcode;
    logic [ADDR_WIDTH-1:0] addr;
    logic [DATA_WIDTH-1:0] gap;
  } spi_rd_cmd_t;

  typedef union packed {
    spi_wr_cmd_t wr;
    spi_rd_cmd_t rd;
  } spi_cmd_t;

endpackage

`default_nettype wire

// File: hdl/spi_link_pkg.sv
`default_nettype none

package spi_link_pkg;

  // same encoding as the opcode bit of the command word
  typedef enum logic {
    OP_READ  = 1'b0,
    OP_WRITE = 1'b1
  } spi_op_t;

  // frame lengths in sclk periods
  localparam int WR_FRAME_BITS = 12;
  localparam int RD_HDR_BITS   = 4;
  localparam int RD_DATA_BITS  = 8;

endpackage

`default_nettype wire

// File: hdl/spi_cmd_decoder.sv
`timescale 1ns/100ps
`default_nettype none

module spi_cmd_decoder (
  input  wire                                     clk,
  input  wire                                     rst_n,
  input  wire spi_cmd_pkg::spi_cmd_t              cmd_in,
  input  wire                                     cmd_vld,
  input  wire                                     done,
  output logic                                    cmd_rdy,
  output logic                                    start,
  output spi_link_pkg::spi_op_t                   op,
  output logic [spi_cmd_pkg::CMD_WIDTH-1:0]       tx_word,
  output logic [spi_cmd_pkg::DATA_WIDTH-1:0]      gap
);

  logic                  busy;
  logic                  accept;
  spi_cmd_pkg::spi_cmd_t cmd_reg;

  assign accept  = cmd_vld && !busy;
  assign cmd_rdy = !busy;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      busy  <= 1'b0;
      start <= 1'b0;
    end
    else
    begin
      start <= accept;
      if (accept)
        busy <= 1'b1;
      else if (done)
        busy <= 1'b0;
    end
  end

  // held until done since no new command is taken while busy
  always_ff @(posedge clk)
  begin
    if (accept)
      cmd_reg <= cmd_in;
  end

  // opcode and full word from the write view, turnaround from the read view
  assign op      = spi_link_pkg::spi_op_t'(cmd_reg.wr.opcode);
  assign tx_word = cmd_reg.wr;
  assign gap     = cmd_reg.rd.gap;

endmodule

`default_nettype wire

// File: hdl/spi_shift_engine.sv
`timescale 1ns/100ps
`default_nettype none

module spi_shift_engine #(
  parameter int CLK_DIV = 4
) (
  input  wire                                          clk,
  input  wire                                          rst_n,
  input  wire                                          start,
  input  wire spi_link_pkg::spi_op_t                   op,
  input  wire [spi_link_pkg::WR_FRAME_BITS-1:0]        tx_word,
  input  wire [spi_cmd_pkg::DATA_WIDTH-1:0]            gap,
  input  wire                                          miso,
  output logic                                         sclk,
  output logic                                         cs_n,
  output logic                                         mosi,
  output logic                                         done,
  output logic                                         sample,
  output logic                                         sample_bit,
  output logic                                         rx_last
);

  localparam int DIV_W = (CLK_DIV > 2) ? $clog2(CLK_DIV) : 1;
  localparam int BIT_W = $clog2(spi_link_pkg::WR_FRAME_BITS + 1);
  localparam int TX_W  = spi_link_pkg::WR_FRAME_BITS;

  localparam logic [2:0] IDLE     = 3'd0;
  localparam logic [2:0] FRAME_TX = 3'd1;
  localparam logic [2:0] GAP      = 3'd2;
  localparam logic [2:0] FRAME_RX = 3'd3;
  localparam logic [2:0] FINISH   = 3'd4;

  logic [2:0]                          state;
  logic [DIV_W-1:0]                    div_cnt;
  logic [BIT_W-1:0]                    bit_cnt;
  logic [BIT_W-1:0]                    frame_bits;
  logic [spi_cmd_pkg::DATA_WIDTH-1:0]  gap_cnt;
  logic [TX_W-1:0]                     tx_sh;
  logic                                in_frame;
  logic                                half_end;
  logic                                last_bit;
  logic                                rise_en;
  logic                                fall_en;
  logic                                frame_end;

  assign in_frame = (state == FRAME_TX) || (state == FRAME_RX);
  assign half_end = (div_cnt == DIV_W'(CLK_DIV - 1));

  // length of the frame in progress
  always_comb
  begin
    if (state == FRAME_RX)
      frame_bits = BIT_W'(spi_link_pkg::RD_DATA_BITS);
    else if (op == spi_link_pkg::OP_WRITE)
      frame_bits = BIT_W'(spi_link_pkg::WR_FRAME_BITS);
    else
      frame_bits = BIT_W'(spi_link_pkg::RD_HDR_BITS);
  end

  assign last_bit = (bit_cnt == frame_bits - 1'b1);

  // a low half ends with sclk rising or with cs_n released after the last bit
  assign frame_end = in_frame && half_end && !sclk && (bit_cnt == frame_bits);
  assign rise_en   = in_frame && half_end && !sclk && (bit_cnt != frame_bits);
  assign fall_en   = in_frame && half_end && sclk;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state   <= IDLE;
      div_cnt <= '0;
      bit_cnt <= '0;
      gap_cnt <= '0;
      sclk    <= 1'b0;
      cs_n    <= 1'b1;
      mosi    <= 1'b0;
      done    <= 1'b0;
      sample  <= 1'b0;
      rx_last <= 1'b0;
    end
    else
    begin
      done    <= 1'b0;
      sample  <= 1'b0;
      rx_last <= 1'b0;

      if (state == IDLE || half_end)
        div_cnt <= '0;
      else
        div_cnt <= div_cnt + 1'b1;

      case (state)
        IDLE:
        begin
          if (start)
          begin
            state   <= FRAME_TX;
            cs_n    <= 1'b0;
            bit_cnt <= '0;
            mosi    <= tx_word[TX_W-1];
          end
        end

        FRAME_TX, FRAME_RX:
        begin
          if (fall_en)
          begin
            sclk    <= 1'b0;
            bit_cnt <= bit_cnt + 1'b1;
            // mosi drops to 0 after the last transmitted bit
            if (state == FRAME_TX && !last_bit)
              mosi <= tx_sh[TX_W-1];
            else
              mosi <= 1'b0;
          end
          else if (rise_en)
          begin
            sclk <= 1'b1;
            if (state == FRAME_RX)
            begin
              sample  <= 1'b1;
              rx_last <= last_bit;
            end
          end
          else if (frame_end)
          begin
            cs_n    <= 1'b1;
            bit_cnt <= '0;
            if (state == FRAME_TX && op == spi_link_pkg::OP_READ)
            begin
              state   <= GAP;
              gap_cnt <= '0;
            end
            else
              state <= FINISH;
          end
        end

        GAP:
        begin
          // cs_n high for (gap+1) half periods
          if (half_end)
          begin
            if (gap_cnt == gap)
            begin
              cs_n  <= 1'b0;
              state <= FRAME_RX;
            end
            else
              gap_cnt <= gap_cnt + 1'b1;
          end
        end

        FINISH:
        begin
          done  <= 1'b1;
          state <= IDLE;
        end

        default:
          state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if (state == IDLE && start)
      tx_sh <= tx_word << 1;
    else if (fall_en && state == FRAME_TX)
      tx_sh <= tx_sh << 1;

    if (rise_en)
      sample_bit <= miso;
  end

endmodule

`default_nettype wire

// File: hdl/spi_read_capture.sv
`timescale 1ns/100ps
`default_nettype none

module spi_read_capture (
  input  wire                                      clk,
  input  wire                                      rst_n,
  input  wire                                      sample,
  input  wire                                      sample_bit,
  input  wire                                      rx_last,
  output logic [spi_cmd_pkg::DATA_WIDTH-1:0]       read_data,
  output logic                                     read_vld
);

  localparam int W = spi_cmd_pkg::DATA_WIDTH;

  logic [W-1:0] rx_sh;
  logic [W-1:0] rx_next;

  // msb first, so new bits enter at the bottom
  assign rx_next = {rx_sh[W-2:0], sample_bit};

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      read_vld <= 1'b0;
    else
      read_vld <= sample && rx_last;
  end

  always_ff @(posedge clk)
  begin
    if (sample)
      rx_sh <= rx_next;
    // byte stays on read_data until the next read completes
    if (sample && rx_last)
      read_data <= rx_next;
  end

endmodule

`default_nettype wire

// File: hdl/spi_cmd_master.sv
`timescale 1ns/100ps
`default_nettype none

module spi_cmd_master #(
  parameter int CLK_DIV = 4
) (
  input  wire                                    clk,
  input  wire                                    rst_n,
  input  wire  [spi_cmd_pkg::CMD_WIDTH-1:0]      cmd_in,
  input  wire                                    cmd_vld,
  output logic                                   cmd_rdy,
  output logic                                   sclk,
  output logic                                   cs_n,
  output logic                                   mosi,
  input  wire                                    miso,
  output logic [spi_cmd_pkg::DATA_WIDTH-1:0]     read_data,
  output logic                                   read_vld
);

  logic                                  start;
  logic                                  done;
  spi_link_pkg::spi_op_t                 op;
  logic [spi_cmd_pkg::CMD_WIDTH-1:0]     tx_word;
  logic [spi_cmd_pkg::DATA_WIDTH-1:0]    gap;
  logic                                  sample;
  logic                                  sample_bit;
  logic                                  rx_last;

  spi_cmd_decoder i_spi_cmd_decoder (
    .clk     (clk),
    .rst_n   (rst_n),
    .cmd_in  (cmd_in),
    .cmd_vld (cmd_vld),
    .done    (done),
    .cmd_rdy (cmd_rdy),
    .start   (start),
    .op      (op),
    .tx_word (tx_word),
    .gap     (gap)
  );

  spi_shift_engine #(
    .CLK_DIV (CLK_DIV)
  ) i_spi_shift_engine (
    .clk        (clk),
    .rst_n      (rst_n),
    .start      (start),
    .op         (op),
    .tx_word    (tx_word),
    .gap        (gap),
    .miso       (miso),
    .sclk       (sclk),
    .cs_n       (cs_n),
    .mosi       (mosi),
    .done       (done),
    .sample     (sample),
    .sample_bit (sample_bit),
    .rx_last    (rx_last)
  );

  spi_read_capture i_spi_read_capture (
    .clk        (clk),
    .rst_n      (rst_n),
    .sample     (sample),
    .sample_bit (sample_bit),
    .rx_last    (rx_last),
    .read_data  (read_data),
    .read_vld   (read_vld)
  );

endmodule

`default_nettype wire

// File: verification/spi_cmd_master_sva.sv
`timescale 1ns/100ps
`default_nettype none

module spi_cmd_master_sva (
  input wire clk,
  input wire rst_n,
  input wire cmd_rdy,
  input wire sclk,
  input wire cs_n,
  input wire read_vld
);

  int fail_count = 0;

  // sclk idles low outside a frame
  property sclk_low_when_deselected;
    @(posedge clk) disable iff (!rst_n) cs_n |-> !sclk;
  endproperty

  property read_vld_single_cycle;
    @(posedge clk) disable iff (!rst_n) read_vld |=> !read_vld;
  endproperty

  // no new command is taken while a frame is on the wire
  property busy_during_frame;
    @(posedge clk) disable iff (!rst_n) !cs_n |-> !cmd_rdy;
  endproperty

  a_sclk_idle: assert property (sclk_low_when_deselected)
    else
    begin
      $error("sclk high while cs_n is high");
      fail_count++;
    end

  a_read_vld_pulse: assert property (read_vld_single_cycle)
    else
    begin
      $error("read_vld high for two cycles in a row");
      fail_count++;
    end

  a_busy_in_frame: assert property (busy_during_frame)
    else
    begin
      $error("cmd_rdy high while cs_n is low");
      fail_count++;
    end

endmodule

`default_nettype wire

// File: verification/spi_cmd_master_tb.sv
`timescale 1ns/100ps
`default_nettype none

module spi_cmd_master_tb;

  localparam int CLK_DIV    = 4;
  localparam int CLK_PERIOD = 20;
  localparam int TIMEOUT    = 2000;

  logic        clk;
  logic        rst_n;
  logic [11:0] cmd_in;
  logic        cmd_vld;
  logic        cmd_rdy;
  logic        sclk;
  logic        cs_n;
  logic        mosi;
  logic        miso;
  logic [7:0]  read_data;
  logic        read_vld;

  logic [31:0] rng_state = 32'd34336;
  logic [31:0] r;
  int          errors = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  int          sva_fails;
  int          errs0;
  int          frames0;
  int          exp_frames;
  logic [7:0]  exp_regs [8];
  logic [7:0]  exp_reads [$];
  int          vld_count = 0;

  // peripheral model
  logic [7:0]  periph_regs [8];
  logic [11:0] frame_word;
  int          frame_bits;
  int          frame_count = 0;
  logic [11:0] last_word;
  int          last_bits;
  logic [11:0] data_word;
  int          data_bits;
  logic        read_pending = 1'b0;
  logic        data_phase = 1'b0;
  logic [7:0]  rd_sh;
  time         hdr_end_t;
  int          gap_cycles;

  spi_cmd_master #(
    .CLK_DIV (CLK_DIV)
  ) i_spi_cmd_master (
    .clk       (clk),
    .rst_n     (rst_n),
    .cmd_in    (cmd_in),
    .cmd_vld   (cmd_vld),
    .cmd_rdy   (cmd_rdy),
    .sclk      (sclk),
    .cs_n      (cs_n),
    .mosi      (mosi),
    .miso      (miso),
    .read_data (read_data),
    .read_vld  (read_vld)
  );

  bind spi_cmd_master spi_cmd_master_sva i_spi_cmd_master_sva (
    .clk      (clk),
    .rst_n    (rst_n),
    .cmd_rdy  (cmd_rdy),
    .sclk     (sclk),
    .cs_n     (cs_n),
    .read_vld (read_vld)
  );

  always #10 clk = ~clk;

  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
      errors++;
    end
  endtask

  task automatic finish_test(input string name, input int errs_before);
    tests_run++;
    if (errors == errs_before)
      $display("test %s: ok", name);
    else
    begin
      tests_failed++;
      $display("test %s: %0d errors", name, errors - errs_before);
    end
  endtask

  task automatic check_reset_levels();
    check_value("cmd_rdy", cmd_rdy, 1);
    check_value("cs_n", cs_n, 1);
    check_value("sclk", sclk, 0);
    check_value("mosi", mosi, 0);
    check_value("read_vld", read_vld, 0);
  endtask

  task automatic check_regs();
    for (int i = 0; i < 8; i++)
      check_value($sformatf("periph_regs[%0d]", i), periph_regs[i], exp_regs[i]);
  endtask

  task automatic wait_ready(input string what);
    int n;
    n = 0;
    while (!cmd_rdy && n < TIMEOUT)
    begin
      @(posedge clk);
      #2;
      n++;
    end
    if (!cmd_rdy)
    begin
      $display("timeout: cmd_rdy stayed low while %s", what);
      errors++;
    end
  endtask

  // presents the command in the first cycle cmd_rdy is high
  task automatic issue_cmd(input logic [11:0] cmd);
    wait_ready("issuing a command");
    cmd_in  = cmd;
    cmd_vld = 1'b1;
    @(posedge clk);
    #2;
    cmd_vld = 1'b0;
    if (cmd[11])
      exp_regs[cmd[10:8]] = cmd[7:0];
    else
      exp_reads.push_back(exp_regs[cmd[10:8]]);
  endtask

  task automatic run_single(input logic [11:0] cmd);
    int f0;
    int v0;
    f0 = frame_count;
    v0 = vld_count;
    issue_cmd(cmd);
    wait_ready("running a command");
    if (cmd[11])
    begin
      check_value("write frame_bits", last_bits, 12);
      check_value("write mosi word", last_word, cmd);
      check_value("frame_count", frame_count - f0, 1);
    end
    else
    begin
      check_value("header frame_bits", last_bits, 4);
      check_value("header mosi word", last_word, cmd[11:8]);
      check_value("data frame_bits", data_bits, 8);
      check_value("data mosi word", data_word, 0);
      check_value("gap_cycles", gap_cycles, (int'(cmd[7:0]) + 1) * CLK_DIV);
      check_value("frame_count", frame_count - f0, 2);
      check_value("read_vld pulses", vld_count - v0, 1);
    end
  endtask

  // random cmd_vld activity while the write is busy must be dropped
  task automatic run_with_noise(input logic [11:0] cmd);
    int f0;
    int n;
    logic [31:0] x;
    f0 = frame_count;
    issue_cmd(cmd);
    n = 0;
    while (!cmd_rdy && n < TIMEOUT)
    begin
      x = next_rand();
      cmd_in  = x[11:0];
      cmd_vld = x[12];
      @(posedge clk);
      #2;
      n++;
    end
    cmd_vld = 1'b0;
    wait_ready("ignoring commands");
    check_value("frame_count", frame_count - f0, 1);
    check_value("write mosi word", last_word, cmd);
    check_regs();
  endtask

  always @(negedge clk)
  begin
    if (rst_n && read_vld)
    begin
      vld_count++;
      if (exp_reads.size() == 0)
      begin
        $display("read_vld pulsed with no read outstanding");
        errors++;
      end
      else
        check_value("read_data", read_data, exp_reads.pop_front());
    end
  end

  always @(negedge cs_n)
  begin
    frame_word = '0;
    frame_bits = 0;
    if (read_pending)
    begin
      data_phase = 1'b1;
      gap_cycles = int'(($time - hdr_end_t) / CLK_PERIOD);
      #2;
      miso = rd_sh[7];
    end
  end

  always @(posedge sclk)
  begin
    if (!cs_n)
    begin
      frame_word = {frame_word[10:0], mosi};
      frame_bits++;
    end
  end

  // next read bit goes out on the falling edge
  always @(negedge sclk)
  begin
    if (data_phase)
    begin
      rd_sh = rd_sh << 1;
      #2;
      miso = rd_sh[7];
    end
  end

  always @(posedge cs_n)
  begin
    if (rst_n)
    begin
      frame_count++;
      if (data_phase)
      begin
        data_word    = frame_word;
        data_bits    = frame_bits;
        data_phase   = 1'b0;
        read_pending = 1'b0;
      end
      else
      begin
        last_word = frame_word;
        last_bits = frame_bits;
        if (frame_bits == 12 && frame_word[11])
          periph_regs[frame_word[10:8]] = frame_word[7:0];
        else if (frame_bits == 4 && !frame_word[3])
        begin
          read_pending = 1'b1;
          rd_sh        = periph_regs[frame_word[2:0]];
          hdr_end_t    = $time;
        end
      end
    end
  end

  initial
  begin
    clk     = 1'b0;
    rst_n   = 1'b0;
    cmd_in  = '0;
    cmd_vld = 1'b0;
    miso    = 1'b0;
    for (int i = 0; i < 8; i++)
    begin
      periph_regs[i] = '0;
      exp_regs[i]    = '0;
    end

    errs0 = errors;
    repeat (16)
    begin
      @(posedge clk);
      #2;
      check_reset_levels();
    end
    rst_n = 1'b1;
    @(posedge clk);
    #2;
    check_reset_levels();
    finish_test("reset levels", errs0);

    errs0 = errors;
    for (int i = 0; i < 16; i++)
    begin
      r = next_rand();
      run_single({1'b1, r[2:0], r[15:8]});
    end
    finish_test("random writes", errs0);

    errs0 = errors;
    for (int i = 0; i < 16; i++)
    begin
      r = next_rand();
      run_single({1'b0, r[2:0], 3'b000, r[12:8]});
    end
    finish_test("random reads", errs0);

    // gap extremes, then full-range random gaps
    errs0 = errors;
    run_single({1'b0, 3'd1, 8'd0});
    run_single({1'b0, 3'd6, 8'd255});
    for (int i = 0; i < 4; i++)
    begin
      r = next_rand();
      run_single({1'b0, r[2:0], r[15:8]});
    end
    finish_test("read gap", errs0);

    errs0 = errors;
    for (int i = 0; i < 6; i++)
    begin
      r = next_rand();
      run_with_noise({1'b1, r[2:0], r[15:8]});
    end
    finish_test("ignored commands", errs0);

    errs0 = errors;
    frames0 = frame_count;
    exp_frames = 0;
    for (int i = 0; i < 24; i++)
    begin
      r = next_rand();
      if (r[16])
        issue_cmd({1'b1, r[2:0], r[15:8]});
      else
        issue_cmd({1'b0, r[2:0], 4'h0, r[11:8]});
      exp_frames += r[16] ? 1 : 2;
    end
    wait_ready("finishing the mixed sequence");
    check_value("frame_count", frame_count - frames0, exp_frames);
    check_value("outstanding reads", exp_reads.size(), 0);
    check_regs();
    finish_test("back-to-back mix", errs0);

    sva_fails = i_spi_cmd_master.i_spi_cmd_master_sva.fail_count;
    $display("%0d tests run, %0d failed, %0d errors, %0d assertion failures",
      tests_run, tests_failed, errors, sva_fails);
    if (errors == 0 && sva_fails == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: spi_cmd_master.f
hdl/spi_cmd_pkg.sv
hdl/spi_link_pkg.sv
hdl/spi_cmd_decoder.sv
hdl/spi_shift_engine.sv
hdl/spi_read_capture.sv
hdl/spi_cmd_master.sv
verification/spi_cmd_master_sva.sv
verification/spi_cmd_master_tb.sv

// File: Bender.yml
package:
  name: spi_cmd_master

sources:
  # packages first, then the module tree bottom up
  - hdl/spi_cmd_pkg.sv
  - hdl/spi_link_pkg.sv
  - hdl/spi_cmd_decoder.sv
  - hdl/spi_shift_engine.sv
  - hdl/spi_read_capture.sv
  - hdl/spi_cmd_master.sv
  - target: simulation
    files:
      - verification/spi_cmd_master_sva.sv
      - verification/spi_cmd_master_tb.sv
